// ==== fma_defines.svh ====
// Binary32 format constants shared by the MAC datapath and its testbench
// Subnormals are not supported anywhere in the unit
`ifndef FMA_DEFINES_SVH
`define FMA_DEFINES_SVH

// Encoded word layout
`define FP_WIDTH 32
`define EXP_WIDTH 8
`define MAN_WIDTH 23

// Exponent bias and the all-ones field used by infinity and NaN
`define EXP_BIAS 127
`define EXP_MAX_FIELD 255

// Extra low bits for guard, round and sticky in the adder
`define GRS_BITS 3

// Only NaN the unit ever produces
`define QNAN_WORD 32'hffc00000

`endif

// ==== fma_pkg.sv ====
// Shared datapath types for the multiply-add unit
// Widths follow fma_defines.svh
`include "fma_defines.svh"

package fma_pkg;

  typedef logic [`FP_WIDTH-1:0] fp_word_t;

  // Unbiased exponent with headroom for overflow and underflow checks
  typedef logic signed [`EXP_WIDTH+1:0] exp_t;

  // Mantissa including the hidden bit
  typedef logic [`MAN_WIDTH:0] man_t;

  // Mantissa plus guard, round and sticky
  typedef logic [`MAN_WIDTH+`GRS_BITS:0] ext_man_t;

  // Adder result with carry out
  typedef logic [`MAN_WIDTH+`GRS_BITS+1:0] sum_t;

  typedef logic [2*`MAN_WIDTH+1:0] prod_t;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    PRESENT
  } ctrl_state_t;

endpackage

// ==== fp_prod_if.sv ====
// Rounded product from the multiplier, sampled by the adder on valid
// Payload holds its value until the next valid pulse
interface fp_prod_if;
  import fma_pkg::*;

  logic valid;
  logic sign;
  exp_t exp;
  man_t man;
  logic is_nan;
  logic is_inf;
  logic is_zero;

  modport source (
    output valid, sign, exp, man, is_nan, is_inf, is_zero
  );

  modport sink (
    input valid, sign, exp, man, is_nan, is_inf, is_zero
  );

endinterface

// ==== mac_handshake.sv ====
// One operand set in flight; input_ack stays low until the answer is taken
// Operands are held stable in a_q..op_q for the whole computation
module mac_handshake (
  input  logic              clk,
  input  logic              rst,
  input  fma_pkg::fp_word_t input_a,
  input  fma_pkg::fp_word_t input_b,
  input  fma_pkg::fp_word_t input_c,
  input  logic              input_op,
  input  logic              input_stb,
  output logic              input_ack,
  output fma_pkg::fp_word_t output_ans,
  output logic              output_ans_stb,
  input  logic              output_ans_ack,
  input  logic              done,
  input  fma_pkg::fp_word_t ans,
  output fma_pkg::fp_word_t a_q,
  output fma_pkg::fp_word_t b_q,
  output fma_pkg::fp_word_t c_q,
  output logic              op_q,
  output logic              start
);
  import fma_pkg::*;

  ctrl_state_t state;
  logic        launch;
  logic        take;
  logic        finish;

  assign take   = (state == IDLE) && input_ack && input_stb;
  assign finish = (state == BUSY) && done;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state          <= IDLE;
      input_ack      <= 1'b0;
      output_ans_stb <= 1'b0;
      launch         <= 1'b0;
      start          <= 1'b0;
    end else begin
      // Start goes out one cycle after the transfer
      launch <= take;
      start  <= launch;
      case (state)
        IDLE: begin
          input_ack <= !take;
          if (take) begin
            state <= BUSY;
          end
        end
        BUSY: begin
          if (done) begin
            output_ans_stb <= 1'b1;
            state          <= PRESENT;
          end
        end
        PRESENT: begin
          if (output_ans_ack) begin
            output_ans_stb <= 1'b0;
            input_ack      <= 1'b1;
            state          <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      a_q  <= input_a;
      b_q  <= input_b;
      c_q  <= input_c;
      op_q <= input_op;
    end
    if (finish) begin
      output_ans <= ans;
    end
  end

  assert property (@(posedge clk) disable iff (!rst)
    output_ans_stb && !output_ans_ack |=> $stable(output_ans))
    else $error("answer changed while waiting for output_ans_ack");

  assert property (@(posedge clk) disable iff (!rst) input_ack |-> state == IDLE)
    else $error("input_ack high while an answer is outstanding");

endmodule

// ==== fp_multiply.sv ====
// Subnormal operands count as zero; products below 2^-126 flush to signed zero
// Three stage pipeline of unpack, multiply, then normalise and round
`include "fma_defines.svh"

module fp_multiply (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  fma_pkg::fp_word_t a_q,
  input  fma_pkg::fp_word_t b_q,
  fp_prod_if.source         prod
);
  import fma_pkg::*;

  localparam int EXP_MSB = `FP_WIDTH - 2;
  localparam int MW      = `MAN_WIDTH + 1;
  localparam int PMSB    = 2 * MW - 1;

  logic a_zero;
  logic a_inf;
  logic a_nan;
  logic b_zero;
  logic b_inf;
  logic b_nan;
  exp_t a_exp;
  exp_t b_exp;

  logic s1_valid;
  logic s1_sign;
  logic s1_nan;
  logic s1_inf;
  logic s1_zero;
  exp_t s1_exp;
  man_t s1_man_a;
  man_t s1_man_b;

  logic  s2_valid;
  logic  s2_sign;
  logic  s2_nan;
  logic  s2_inf;
  logic  s2_zero;
  exp_t  s2_exp;
  prod_t s2_prod;

  man_t            norm_man;
  logic            guard;
  logic            sticky;
  logic            round_up;
  exp_t            norm_exp;
  logic [MW:0]     rounded;
  man_t            round_man;
  exp_t            round_exp;

  assign a_zero = a_q[EXP_MSB -: `EXP_WIDTH] == '0;
  assign b_zero = b_q[EXP_MSB -: `EXP_WIDTH] == '0;
  assign a_inf  = a_q[EXP_MSB -: `EXP_WIDTH] == `EXP_MAX_FIELD && a_q[`MAN_WIDTH-1:0] == '0;
  assign b_inf  = b_q[EXP_MSB -: `EXP_WIDTH] == `EXP_MAX_FIELD && b_q[`MAN_WIDTH-1:0] == '0;
  assign a_nan  = a_q[EXP_MSB -: `EXP_WIDTH] == `EXP_MAX_FIELD && a_q[`MAN_WIDTH-1:0] != '0;
  assign b_nan  = b_q[EXP_MSB -: `EXP_WIDTH] == `EXP_MAX_FIELD && b_q[`MAN_WIDTH-1:0] != '0;
  assign a_exp  = exp_t'({2'b00, a_q[EXP_MSB -: `EXP_WIDTH]}) - exp_t'(`EXP_BIAS);
  assign b_exp  = exp_t'({2'b00, b_q[EXP_MSB -: `EXP_WIDTH]}) - exp_t'(`EXP_BIAS);

  always_ff @(posedge clk) begin
    if (!rst) begin
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      prod.valid <= 1'b0;
    end else begin
      s1_valid   <= start;
      s2_valid   <= s1_valid;
      prod.valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      s1_sign  <= a_q[`FP_WIDTH-1] ^ b_q[`FP_WIDTH-1];
      // Inf times zero is invalid
      s1_nan   <= a_nan | b_nan | (a_inf & b_zero) | (b_inf & a_zero);
      s1_inf   <= a_inf | b_inf;
      s1_zero  <= a_zero | b_zero;
      s1_exp   <= a_exp + b_exp;
      s1_man_a <= {1'b1, a_q[`MAN_WIDTH-1:0]};
      s1_man_b <= {1'b1, b_q[`MAN_WIDTH-1:0]};
    end
    if (s1_valid) begin
      s2_sign <= s1_sign;
      s2_nan  <= s1_nan;
      s2_inf  <= s1_inf;
      s2_zero <= s1_zero;
      s2_exp  <= s1_exp;
      s2_prod <= prod_t'(s1_man_a) * prod_t'(s1_man_b);
    end
  end

  // Product of two 1.x mantissas lies in [1, 4)
  always_comb begin
    if (s2_prod[PMSB]) begin
      norm_man = s2_prod[PMSB -: MW];
      guard    = s2_prod[PMSB-MW];
      sticky   = |s2_prod[PMSB-MW-1:0];
      norm_exp = s2_exp + exp_t'(1);
    end else begin
      norm_man = s2_prod[PMSB-1 -: MW];
      guard    = s2_prod[PMSB-MW-1];
      sticky   = |s2_prod[PMSB-MW-2:0];
      norm_exp = s2_exp;
    end
    round_up = guard & (sticky | norm_man[0]);
    rounded  = {1'b0, norm_man} + {{MW{1'b0}}, round_up};
    if (rounded[MW]) begin
      round_man = rounded[MW:1];
      round_exp = norm_exp + exp_t'(1);
    end else begin
      round_man = rounded[MW-1:0];
      round_exp = norm_exp;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      prod.sign    <= s2_sign;
      prod.exp     <= round_exp;
      prod.man     <= round_man;
      prod.is_nan  <= s2_nan;
      prod.is_inf  <= !s2_nan && (s2_inf || (!s2_zero && round_exp > exp_t'(`EXP_BIAS)));
      prod.is_zero <= !s2_nan && !s2_inf &&
                      (s2_zero || round_exp < exp_t'(1 - `EXP_BIAS));
    end
  end

  assert property (@(posedge clk) disable iff (!rst) prod.valid |=> !prod.valid)
    else $error("product valid wider than one cycle");

endmodule

// ==== fp_add_round.sv ====
// Adds c, negated when op_q is 0, to the rounded product; exact zero sums give +0
// Sums below 2^-126 flush to signed zero; done follows prod.valid by 4 cycles
`include "fma_defines.svh"

module fp_add_round (
  input  logic              clk,
  input  logic              rst,
  input  logic              op_q,
  input  fma_pkg::fp_word_t c_q,
  fp_prod_if.sink           prod,
  output fma_pkg::fp_word_t ans,
  output logic              done
);
  import fma_pkg::*;

  localparam int EXP_MSB = `FP_WIDTH - 2;
  // Position of the hidden bit in ext_man_t
  localparam int EXT_MSB = `MAN_WIDTH + `GRS_BITS;
  localparam logic [`EXP_WIDTH-1:0] EXP_ONES = `EXP_MAX_FIELD;

  logic                  c_sign;
  logic                  c_zero;
  logic                  c_inf;
  logic                  c_nan;
  exp_t                  c_exp;
  exp_t                  p_biased;
  ext_man_t              c_ext;
  ext_man_t              p_ext;
  exp_t                  exp_diff;
  logic                  c_bigger;
  logic [`EXP_WIDTH+1:0] shift;
  logic                  special;
  fp_word_t              special_word;

  logic     s1_valid;
  logic     s1_special;
  fp_word_t s1_word;
  ext_man_t s1_big;
  ext_man_t s1_small;
  logic     s1_big_sign;
  logic     s1_small_sign;
  exp_t     s1_exp;

  logic     s2_valid;
  logic     s2_special;
  fp_word_t s2_word;
  sum_t     s2_sum;
  logic     s2_sign;
  exp_t     s2_exp;

  logic     s3_valid;
  logic     s3_special;
  fp_word_t s3_word;
  ext_man_t s3_man;
  logic     s3_sign;
  logic     s3_zero;
  exp_t     s3_exp;

  logic [4:0]            lz;
  ext_man_t              norm_man;
  exp_t                  norm_exp;
  logic                  round_up;
  logic [`MAN_WIDTH+1:0] rounded;
  exp_t                  final_exp;
  exp_t                  biased;
  fp_word_t              pack_word;

  // Right shift that folds every bit shifted out into bit 0
  function automatic ext_man_t shift_sticky(input ext_man_t m, input logic [`EXP_WIDTH+1:0] sh);
    ext_man_t res;
    ext_man_t lost;
    if (sh > EXT_MSB) begin
      res = {{EXT_MSB{1'b0}}, |m};
    end else begin
      res    = m >> sh;
      lost   = m & ~({(EXT_MSB+1){1'b1}} << sh);
      res[0] = res[0] | (|lost);
    end
    return res;
  endfunction

  function automatic logic [4:0] lead_zeros(input ext_man_t m);
    logic [4:0] n;
    n = '0;
    for (int i = 0; i <= EXT_MSB; i++) begin
      if (m[i]) n = 5'(EXT_MSB - i);
    end
    return n;
  endfunction

  assign c_sign   = c_q[`FP_WIDTH-1] ^ ~op_q;
  assign c_zero   = c_q[EXP_MSB -: `EXP_WIDTH] == '0;
  assign c_inf    = c_q[EXP_MSB -: `EXP_WIDTH] == `EXP_MAX_FIELD && c_q[`MAN_WIDTH-1:0] == '0;
  assign c_nan    = c_q[EXP_MSB -: `EXP_WIDTH] == `EXP_MAX_FIELD && c_q[`MAN_WIDTH-1:0] != '0;
  assign c_exp    = exp_t'({2'b00, c_q[EXP_MSB -: `EXP_WIDTH]}) - exp_t'(`EXP_BIAS);
  assign p_biased = prod.exp + exp_t'(`EXP_BIAS);
  assign c_ext    = {1'b1, c_q[`MAN_WIDTH-1:0], {`GRS_BITS{1'b0}}};
  assign p_ext    = {prod.man, {`GRS_BITS{1'b0}}};
  assign exp_diff = prod.exp - c_exp;
  assign c_bigger = exp_diff < 0;
  assign shift    = c_bigger ? -exp_diff : exp_diff;

  always_comb begin
    special      = 1'b1;
    special_word = '0;
    if (prod.is_nan || c_nan || (prod.is_inf && c_inf && prod.sign != c_sign)) begin
      special_word = `QNAN_WORD;
    end else if (prod.is_inf) begin
      special_word = {prod.sign, EXP_ONES, {`MAN_WIDTH{1'b0}}};
    end else if (c_inf) begin
      special_word = {c_sign, EXP_ONES, {`MAN_WIDTH{1'b0}}};
    end else if (prod.is_zero && c_zero) begin
      special_word = {prod.sign & c_sign, {(`FP_WIDTH-1){1'b0}}};
    end else if (prod.is_zero) begin
      special_word = {c_sign, c_q[`FP_WIDTH-2:0]};
    end else if (c_zero) begin
      special_word = {prod.sign, p_biased[`EXP_WIDTH-1:0], prod.man[`MAN_WIDTH-1:0]};
    end else begin
      special = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      s1_valid <= prod.valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
      done     <= s3_valid;
    end
  end

  // Align, then add or subtract magnitudes
  always_ff @(posedge clk) begin
    if (prod.valid) begin
      s1_special    <= special;
      s1_word       <= special_word;
      s1_exp        <= c_bigger ? c_exp : prod.exp;
      s1_big_sign   <= c_bigger ? c_sign : prod.sign;
      s1_small_sign <= c_bigger ? prod.sign : c_sign;
      s1_big        <= c_bigger ? c_ext : p_ext;
      s1_small      <= shift_sticky(c_bigger ? p_ext : c_ext, shift);
    end
    if (s1_valid) begin
      s2_special <= s1_special;
      s2_word    <= s1_word;
      s2_exp     <= s1_exp;
      if (s1_big_sign == s1_small_sign) begin
        s2_sum  <= sum_t'(s1_big) + sum_t'(s1_small);
        s2_sign <= s1_big_sign;
      end else if (s1_big >= s1_small) begin
        s2_sum  <= sum_t'(s1_big - s1_small);
        s2_sign <= s1_big_sign;
      end else begin
        // Only possible with equal exponents
        s2_sum  <= sum_t'(s1_small - s1_big);
        s2_sign <= s1_small_sign;
      end
    end
  end

  always_comb begin
    lz = lead_zeros(s2_sum[EXT_MSB:0]);
    if (s2_sum[EXT_MSB+1]) begin
      norm_man = {s2_sum[EXT_MSB+1:2], s2_sum[1] | s2_sum[0]};
      norm_exp = s2_exp + exp_t'(1);
    end else begin
      norm_man = s2_sum[EXT_MSB:0] << lz;
      norm_exp = s2_exp - exp_t'(lz);
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      s3_special <= s2_special;
      s3_word    <= s2_word;
      s3_man     <= norm_man;
      s3_exp     <= norm_exp;
      s3_sign    <= s2_sign;
      s3_zero    <= s2_sum == '0;
    end
  end

  always_comb begin
    round_up  = s3_man[`GRS_BITS-1] &
                (s3_man[`GRS_BITS-2] | s3_man[0] | s3_man[`GRS_BITS]);
    rounded   = {1'b0, s3_man[EXT_MSB:`GRS_BITS]} + {{(`MAN_WIDTH+1){1'b0}}, round_up};
    final_exp = rounded[`MAN_WIDTH+1] ? s3_exp + exp_t'(1) : s3_exp;
    biased    = final_exp + exp_t'(`EXP_BIAS);
    if (s3_special) begin
      pack_word = s3_word;
    end else if (s3_zero) begin
      pack_word = '0;
    end else if (final_exp > exp_t'(`EXP_BIAS)) begin
      pack_word = {s3_sign, EXP_ONES, {`MAN_WIDTH{1'b0}}};
    end else if (final_exp < exp_t'(1 - `EXP_BIAS)) begin
      pack_word = {s3_sign, {(`FP_WIDTH-1){1'b0}}};
    end else begin
      pack_word = {s3_sign, biased[`EXP_WIDTH-1:0], rounded[`MAN_WIDTH-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (s3_valid) begin
      ans <= pack_word;
    end
  end

  assert property (@(posedge clk) disable iff (!rst) prod.valid |-> ##4 done)
    else $error("done did not follow product valid by four cycles");

endmodule

// ==== fp_mac_top.sv ====
// Binary32 a*b +/- c with the product rounded before the add; subnormals act as zero
// One operand set at a time; output_ans_stb rises 9 cycles after the input transfer
module fp_mac_top (
  input  logic              clk,
  input  logic              rst,
  input  fma_pkg::fp_word_t input_a,
  input  fma_pkg::fp_word_t input_b,
  input  fma_pkg::fp_word_t input_c,
  input  logic              input_op,
  input  logic              input_stb,
  output logic              input_ack,
  output fma_pkg::fp_word_t output_ans,
  output logic              output_ans_stb,
  input  logic              output_ans_ack
);
  import fma_pkg::*;

  fp_word_t a_q;
  fp_word_t b_q;
  fp_word_t c_q;
  fp_word_t ans;
  logic     op_q;
  logic     start;
  logic     done;

  fp_prod_if prod_bus ();

  mac_handshake u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .input_a        (input_a),
    .input_b        (input_b),
    .input_c        (input_c),
    .input_op       (input_op),
    .input_stb      (input_stb),
    .input_ack      (input_ack),
    .output_ans     (output_ans),
    .output_ans_stb (output_ans_stb),
    .output_ans_ack (output_ans_ack),
    .done           (done),
    .ans            (ans),
    .a_q            (a_q),
    .b_q            (b_q),
    .c_q            (c_q),
    .op_q           (op_q),
    .start          (start)
  );

  fp_multiply u_mul (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .a_q   (a_q),
    .b_q   (b_q),
    .prod  (prod_bus.source)
  );

  fp_add_round u_add (
    .clk  (clk),
    .rst  (rst),
    .op_q (op_q),
    .c_q  (c_q),
    .prod (prod_bus.sink),
    .ans  (ans),
    .done (done)
  );

endmodule

// ==== tb_fp_mac_vectors.svh ====
// Operand sets and expected answers for tb_fp_mac, included inside the module body
// Values are exact in binary32 except the hand-worked rounding ties
`ifndef TB_FP_MAC_VECTORS_SVH
`define TB_FP_MAC_VECTORS_SVH

typedef struct packed {
  logic [`FP_WIDTH-1:0] a;
  logic [`FP_WIDTH-1:0] b;
  logic [`FP_WIDTH-1:0] c;
  logic                 op;
  logic [`FP_WIDTH-1:0] want;
} mac_vector_t;

localparam int NUM_VECTORS = 27;

// Columns are a, b, c, op (1 add, 0 subtract) and the expected answer
localparam mac_vector_t VECTORS [NUM_VECTORS] = '{
  // Plain multiply-add
  {32'h40400000, 32'h40a00000, 32'hc0200000, 1'b1, 32'h41480000},
  {32'h40000000, 32'h40000000, 32'h3f800000, 1'b1, 32'h40a00000},
  {32'hc0400000, 32'h40000000, 32'h3f800000, 1'b1, 32'hc0a00000},
  {32'h3fc00000, 32'h3fc00000, 32'h3e800000, 1'b1, 32'h40200000},
  // Subtraction where the first one cancels to +0
  {32'h40400000, 32'h40a00000, 32'h41700000, 1'b0, 32'h00000000},
  {32'h40000000, 32'h40000000, 32'h3f800000, 1'b0, 32'h40400000},
  {32'h3f800000, 32'h3f800000, 32'h40400000, 1'b0, 32'hc0000000},
  {32'hc0000000, 32'hc0000000, 32'hbf800000, 1'b0, 32'h40a00000},
  // NaN cases
  {32'h7fc00000, 32'h3f800000, 32'h3f800000, 1'b1, `QNAN_WORD},
  {32'h7f800000, 32'h00000000, 32'h3f800000, 1'b1, `QNAN_WORD},
  {32'h7f800000, 32'h3f800000, 32'hff800000, 1'b1, `QNAN_WORD},
  {32'h7f800000, 32'h3f800000, 32'h7f800000, 1'b0, `QNAN_WORD},
  {32'h40000000, 32'h40000000, 32'h7f800001, 1'b1, `QNAN_WORD},
  // Infinity plus finite
  {32'h7f800000, 32'h40000000, 32'h40a00000, 1'b1, 32'h7f800000},
  {32'hff800000, 32'h40000000, 32'h40a00000, 1'b1, 32'hff800000},
  // Infinite c takes its sign after op
  {32'h3f800000, 32'h3f800000, 32'h7f800000, 1'b0, 32'hff800000},
  // Subnormal a acts as zero
  {32'h00000001, 32'h40000000, 32'h40400000, 1'b1, 32'h40400000},
  {32'h00400000, 32'h3f800000, 32'h40400000, 1'b0, 32'hc0400000},
  // 2^100 squared overflows and 2^-100 squared flushes
  {32'h71800000, 32'h71800000, 32'h3f800000, 1'b1, 32'h7f800000},
  {32'hf1800000, 32'h71800000, 32'h3f800000, 1'b1, 32'hff800000},
  {32'h0d800000, 32'h0d800000, 32'h3f800000, 1'b1, 32'h3f800000},
  // Signed zeros
  {32'h80000000, 32'h3f800000, 32'h80000000, 1'b1, 32'h80000000},
  {32'h00000000, 32'h3f800000, 32'h00000000, 1'b0, 32'h00000000},
  // Ties where 1 + 2^-24 stays even and 1 + 3*2^-24 or an odd lsb rounds up
  {32'h3f800000, 32'h3f800000, 32'h33800000, 1'b1, 32'h3f800000},
  {32'h3f800000, 32'h3f800000, 32'h34400000, 1'b1, 32'h3f800002},
  {32'h3f800001, 32'h3f800000, 32'h33800000, 1'b1, 32'h3f800002},
  // 1 - 2^-24 needs a one-bit left normalise
  {32'h3f800000, 32'h3f800000, 32'h33800000, 1'b0, 32'h3f7fffff}
};

`endif

// ==== tb_fp_mac.sv ====
// Pushes every table vector through the strobe/acknowledge handshake of fp_mac_top
// Answers are taken under random output_ans_ack stalls; any failure ends the run
`include "fma_defines.svh"

module tb_fp_mac;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_fp_mac_vectors.svh"

  localparam int WAIT_LIMIT = 50;

  logic                 clk;
  logic                 rst;
  logic [`FP_WIDTH-1:0] input_a;
  logic [`FP_WIDTH-1:0] input_b;
  logic [`FP_WIDTH-1:0] input_c;
  logic                 input_op;
  logic                 input_stb;
  logic                 input_ack;
  logic [`FP_WIDTH-1:0] output_ans;
  logic                 output_ans_stb;
  logic                 output_ans_ack;
  integer               seed;

  fp_mac_top uut (
    .clk            (clk),
    .rst            (rst),
    .input_a        (input_a),
    .input_b        (input_b),
    .input_c        (input_c),
    .input_op       (input_op),
    .input_stb      (input_stb),
    .input_ack      (input_ack),
    .output_ans     (output_ans),
    .output_ans_stb (output_ans_stb),
    .output_ans_ack (output_ans_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic compare_value(input logic [`FP_WIDTH-1:0] got,
                               input logic [`FP_WIDTH-1:0] want,
                               input string what, input int idx);
    if (got !== want) begin
      $display("ERROR at %0t: vector %0d, %s is %h, expected %h", $time, idx, what, got, want);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_on_timeout(input string what, input int idx);
    $display("Timed out after %0d cycles waiting for %s on vector %0d", WAIT_LIMIT, what, idx);
    $display("Done: errors found");
    $fatal(1, "handshake timeout");
  endtask

  // Roughly half the cycles stall the answer
  task automatic drive_random_ack();
    logic [31:0] rnd;
    rnd = $random(seed);
    output_ans_ack = rnd[0];
  endtask

  task automatic send_operands(input int idx);
    mac_vector_t vec;
    int          waited;
    vec    = VECTORS[idx];
    waited = 0;
    @(negedge clk);
    input_a   = vec.a;
    input_b   = vec.b;
    input_c   = vec.c;
    input_op  = vec.op;
    input_stb = 1'b1;
    while (!input_ack) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_on_timeout("input_ack", idx);
      end
    end
    // Transfer happens on the rising edge in between
    @(negedge clk);
    input_stb = 1'b0;
    // Scramble the bus so a late capture would show up
    input_a   = ~vec.a;
    input_b   = ~vec.b;
    input_c   = ~vec.c;
    input_op  = ~vec.op;
    compare_value({31'b0, input_ack}, 32'd0, "input_ack after transfer", idx);
  endtask

  task automatic collect_answer(input int idx);
    mac_vector_t vec;
    int          waited;
    vec    = VECTORS[idx];
    waited = 0;
    while (!output_ans_stb) begin
      compare_value({31'b0, input_ack}, 32'd0, "input_ack while busy", idx);
      @(negedge clk);
      drive_random_ack();
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_on_timeout("output_ans_stb", idx);
      end
    end
    compare_value(output_ans, vec.want, "output_ans", idx);
    waited = 0;
    while (!output_ans_ack) begin
      @(negedge clk);
      drive_random_ack();
      compare_value({31'b0, output_ans_stb}, 32'd1, "output_ans_stb under stall", idx);
      compare_value(output_ans, vec.want, "output_ans under stall", idx);
      compare_value({31'b0, input_ack}, 32'd0, "input_ack under stall", idx);
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_on_timeout("output_ans_ack", idx);
      end
    end
    // Answer consumed on the rising edge in between
    @(negedge clk);
    output_ans_ack = 1'b0;
    compare_value({31'b0, output_ans_stb}, 32'd0, "output_ans_stb after consume", idx);
    compare_value({31'b0, input_ack}, 32'd1, "input_ack after consume", idx);
  endtask

  initial begin
    seed           = 32'h22d92566;
    rst            = 1'b0;
    input_a        = '0;
    input_b        = '0;
    input_c        = '0;
    input_op       = 1'b0;
    input_stb      = 1'b0;
    output_ans_ack = 1'b0;
    repeat (16) @(negedge clk);
    compare_value({31'b0, input_ack}, 32'd0, "input_ack in reset", 0);
    compare_value({31'b0, output_ans_stb}, 32'd0, "output_ans_stb in reset", 0);
    rst = 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      send_operands(i);
      collect_answer(i);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+.
fma_pkg.sv
fp_prod_if.sv
mac_handshake.sv
fp_multiply.sv
fp_add_round.sv
fp_mac_top.sv
tb_fp_mac.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fp_mac_top testbench with Verilator.
# Exit status is nonzero when the testbench stops with $fatal.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fp_mac -f project.f -o tb_fp_mac
./obj_dir/tb_fp_mac
